//--- build.f
verilog/pdp8_io_pkg.sv
verilog/iot_if.sv
verilog/tty_unit.sv
verilog/cpu_ctrl_unit.sv
verilog/io_mux.sv
verilog/pdp8_io_top.sv
tb/pdp8_io_tb.sv

//--- run.sh
#!/bin/sh
# compile the IOT path testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pdp8_io_tb -f build.f -o pdp8_io_sim \
    && out=$(./obj_dir/pdp8_io_sim 2>&1; true) \
    && echo "$out" \
    && echo "$out" | grep -q "All checks passed" \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }

//--- tb/pdp8_io_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the IOT path with random requests,
// keyboard and printer traffic and a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module pdp8_io_tb;

    localparam int seed_init      = 46230;
    localparam int num_requests   = 1500;
    localparam int cycles_per_req = 20;
    localparam int clk_period     = 8;
    localparam int reset_cycles   = 8;
    localparam int timeout_ns     = (reset_cycles + num_requests * cycles_per_req) * clk_period;

    // legal fixed-code IOTs, field ops and illegal words are built in drive_inputs
    localparam logic [11:0] op_table [15] = '{
        12'o6000, 12'o6001, 12'o6002, 12'o6003, 12'o6004, 12'o6214, 12'o6224,
        12'o6031, 12'o6032, 12'o6034, 12'o6036, 12'o6041, 12'o6042, 12'o6044, 12'o6046
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        iot_valid, iot_ready;
    logic [11:0] instruction, ac;
    logic        rsp_valid, rsp_ready;
    logic [11:0] in_bus;
    logic        skip, clear_ac;
    logic        kbd_valid, kbd_ready;
    logic [7:0]  kbd_data;
    logic        tx_valid, tx_ready;
    logic [7:0]  tx_data;
    logic        int_request;
    logic [11:0] bus_display;

    // reference model state
    logic        m_rsp_valid, m_skip, m_clear_ac;
    logic [11:0] m_in_bus, m_display;
    logic        m_kbd_flag, m_kbd_seen, m_prt_flag, m_tx_valid;
    logic [7:0]  m_kbd_buf, m_tx_data;
    logic        m_int_en, m_int_request;
    logic [2:0]  m_df, m_if;

    integer      seed = seed_init;
    int          n_accepted = 0;
    int          n_taken = 0;
    int          fail_count = 0;
    logic        req_pending = 1'b0;

    pdp8_io_top pdp8_io_top_inst (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [11:0] actual,
                               input logic [11:0] expected);
        if (actual !== expected) begin
            fail_count++;
            $display("** Error: %s is %h, expected %h at %0t ns", name, actual, expected, $time);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // registered outputs, sampled 1 ns after the edge
    task automatic check_outputs();
        check_value("rsp_valid", 12'(rsp_valid), 12'(m_rsp_valid));
        if (m_rsp_valid) begin
            check_value("in_bus", in_bus, m_in_bus);
            check_value("skip", 12'(skip), 12'(m_skip));
            check_value("clear_ac", 12'(clear_ac), 12'(m_clear_ac));
        end
        check_value("kbd_ready", 12'(kbd_ready), 12'(!m_kbd_flag));
        check_value("tx_valid", 12'(tx_valid), 12'(m_tx_valid));
        if (m_tx_valid)
            check_value("tx_data", 12'(tx_data), 12'(m_tx_data));
        check_value("int_request", 12'(int_request), 12'(m_int_request));
        check_value("bus_display", bus_display, m_display);
    endtask

    task automatic drive_inputs(input logic allow_req);
        int          idx;
        logic [11:0] noise;
        logic [11:0] pick;
        idx   = ($random(seed) & 32'h7fff_ffff) % 20;
        noise = 12'($random(seed));
        if (idx < 15)
            pick = op_table[idx];
        else if (idx == 15)
            pick = {6'o62, noise[2:0], 3'o1};       // CDF N
        else if (idx == 16)
            pick = {6'o62, noise[2:0], 3'o2};       // CIF N
        else if (idx == 17)
            pick = noise;
        else
            pick = {3'o6, noise[8:0]};              // mostly unowned IOTs
        // buffer is undefined until a first byte arrives
        if (!m_kbd_seen && (pick == 12'o6034 || pick == 12'o6036))
            pick = 12'o6031;
        if (!req_pending) begin                     // a stalled request holds
            iot_valid   = allow_req && (($random(seed) & 3) != 0);
            instruction = pick;
            ac          = 12'($random(seed));
        end
        rsp_ready = allow_req ? (($random(seed) & 3) != 0) : 1'b1;
        tx_ready  = ($random(seed) & 1) != 0;
        kbd_valid = ($random(seed) & 3) == 0;
        kbd_data  = 8'($random(seed));
    endtask

    // next model state from the handshakes at the coming edge
    task automatic step_model();
        logic [11:0] d;
        logic        s;
        logic        c;
        logic        accept;
        logic        kbd_take;
        logic        nxt_kbd, nxt_prt, nxt_txv, nxt_int;
        check_value("iot_ready", 12'(iot_ready), 12'(!m_rsp_valid || rsp_ready));
        accept   = iot_valid && (!m_rsp_valid || rsp_ready);
        kbd_take = kbd_valid && !m_kbd_flag;
        nxt_int  = m_int_en && (m_kbd_flag || m_prt_flag);
        nxt_kbd  = m_kbd_flag;
        nxt_prt  = m_prt_flag;
        nxt_txv  = m_tx_valid;
        if (m_tx_valid && tx_ready) begin           // printer took the byte
            nxt_txv = 1'b0;
            nxt_prt = 1'b1;
        end
        d = '0;
        s = 1'b0;
        c = 1'b0;
        if (accept) begin
            case (instruction)
                12'o6000, 12'o6003: begin
                    s = m_int_en;
                    m_int_en = 1'b0;
                end
                12'o6001: begin
                    m_int_en  = 1'b1;
                    m_display = ac;
                end
                12'o6002: m_int_en = 1'b0;
                12'o6004: begin
                    d[10]     = m_int_en;           // machine bit 1
                    d[2:0]    = m_df;
                    m_display = d;
                end
                12'o6214: d[5:3] = m_df;
                12'o6224: d[5:3] = m_if;
                12'o6031: s = m_kbd_flag;
                12'o6032: begin
                    c = 1'b1;
                    nxt_kbd = 1'b0;
                end
                12'o6034: d = {4'b0000, m_kbd_buf};
                12'o6036: begin
                    d = {4'b0000, m_kbd_buf};
                    c = 1'b1;
                    nxt_kbd   = 1'b0;
                    m_display = d;
                end
                12'o6041: s = m_prt_flag;
                12'o6042: nxt_prt = 1'b0;
                12'o6044, 12'o6046: begin
                    if (instruction[1])
                        nxt_prt = 1'b0;             // TLS clears the flag
                    nxt_txv   = 1'b1;
                    m_tx_data = ac[7:0];
                    m_display = ac;
                end
                default: begin
                    if (instruction[11:6] == 6'o62 && instruction[2:0] == 3'o1)
                        m_df = instruction[5:3];
                    else if (instruction[11:6] == 6'o62 && instruction[2:0] == 3'o2)
                        m_if = instruction[5:3];
                end
            endcase
        end
        if (kbd_take) begin
            nxt_kbd    = 1'b1;
            m_kbd_buf  = kbd_data;
            m_kbd_seen = 1'b1;
        end
        if (rsp_valid && rsp_ready)                 // response taken at the port
            n_taken++;
        if (accept) begin
            m_rsp_valid = 1'b1;
            m_in_bus    = d;
            m_skip      = s;
            m_clear_ac  = c;
            n_accepted++;
        end else if (rsp_ready) begin
            m_rsp_valid = 1'b0;
        end
        req_pending   = iot_valid && !accept;
        m_kbd_flag    = nxt_kbd;
        m_prt_flag    = nxt_prt;
        m_tx_valid    = nxt_txv;
        m_int_request = nxt_int;
    endtask

    task automatic run_cycle(input logic allow_req);
        check_outputs();
        drive_inputs(allow_req);
        #1;
        step_model();
        @(posedge clk);
        #1;
    endtask

    initial begin
        reset       = 1'b1;
        iot_valid   = 1'b0;
        instruction = '0;
        ac          = '0;
        rsp_ready   = 1'b0;
        kbd_valid   = 1'b0;
        kbd_data    = '0;
        tx_ready    = 1'b0;
        m_rsp_valid = 1'b0;
        m_skip      = 1'b0;
        m_clear_ac  = 1'b0;
        m_in_bus    = '0;
        m_display   = '0;
        m_kbd_flag  = 1'b0;
        m_kbd_seen  = 1'b0;
        m_prt_flag  = 1'b0;
        m_tx_valid  = 1'b0;
        m_kbd_buf   = '0;
        m_tx_data   = '0;
        m_int_en    = 1'b0;
        m_int_request = 1'b0;
        m_df        = '0;
        m_if        = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        while (n_accepted < num_requests)
            run_cycle(1'b1);
        while (m_rsp_valid || req_pending)     // drain the last response
            run_cycle(1'b0);
        check_outputs();
        check_value("response count", 12'(n_taken), 12'(n_accepted));
        if (fail_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before all requests were answered");
        $display("Checks failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- verilog/pdp8_io_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IOT path top level with mux and both devices
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module pdp8_io_top
    import pdp8_io_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    // request from CPU
    input  logic              iot_valid,
    output logic              iot_ready,
    input  word_t             instruction,
    input  word_t             ac,
    // response to CPU
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output word_t             in_bus,
    output logic              skip,
    output logic              clear_ac,
    // teletype byte ports
    input  logic              kbd_valid,
    input  logic [0:char_w-1] kbd_data,
    output logic              kbd_ready,
    output logic              tx_valid,
    output logic [0:char_w-1] tx_data,
    input  logic              tx_ready,
    output logic              int_request,
    output word_t             bus_display
);

    logic tty_flag;

    iot_if tty_link ();
    iot_if cpu_link ();

    io_mux io_mux_inst (
        .clk         (clk),
        .reset       (reset),
        .iot_valid   (iot_valid),
        .iot_ready   (iot_ready),
        .instruction (instruction),
        .ac          (ac),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .in_bus      (in_bus),
        .skip        (skip),
        .clear_ac    (clear_ac),
        .bus_display (bus_display),
        .tty         (tty_link.host),
        .cpu         (cpu_link.host)
    );

    tty_unit tty_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .link      (tty_link.device),
        .kbd_valid (kbd_valid),
        .kbd_data  (kbd_data),
        .kbd_ready (kbd_ready),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .flag_any  (tty_flag)
    );

    cpu_ctrl_unit cpu_ctrl_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .link        (cpu_link.device),
        .tty_flag    (tty_flag),
        .int_request (int_request)
    );

endmodule

`default_nettype wire

//--- verilog/io_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IOT decode and device strobes, registered
// response to the CPU and the bus display register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module io_mux
    import pdp8_io_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  iot_valid,
    output logic  iot_ready,
    input  word_t instruction,
    input  word_t ac,
    output logic  rsp_valid,
    input  logic  rsp_ready,
    output word_t in_bus,
    output logic  skip,
    output logic  clear_ac,
    output word_t bus_display,
    iot_if.host   tty,
    iot_if.host   cpu
);

    iot_op_e dec_op;
    logic    dec_dev;
    logic    accept;
    word_t   rd_data;

    function automatic iot_op_e decode_iot(input word_t instr);
        iot_op_e op;
        op = IOT_NOP;
        if (instr[0:2] == iot_opcode) begin
            if (instr[3:8] == dev_code_cpu) begin
                case (instr[9:11])
                    3'o0, 3'o3: op = SKON;
                    3'o1:       op = ION;
                    3'o2:       op = IOF;
                    3'o4:       op = GTF;
                    default: ;
                endcase
            end else if (instr[3:8] == dev_code_kbd) begin
                case (instr[9:11])
                    3'o1: op = KSF;
                    3'o2: op = KCC;
                    3'o4: op = KRS;
                    3'o6: op = KRB;
                    default: ;
                endcase
            end else if (instr[3:8] == dev_code_prt) begin
                case (instr[9:11])
                    3'o1: op = TSF;
                    3'o2: op = TCF;
                    3'o4: op = TPC;
                    3'o6: op = TLS;
                    default: ;
                endcase
            end else if (instr[3:5] == mem_group) begin
                case (instr[9:11])
                    3'o1: op = CDF;
                    3'o2: op = CIF;
                    3'o4: begin                         // 6214 and 6224 only
                        if (instr[6:8] == 3'o1)
                            op = RDF;
                        else if (instr[6:8] == 3'o2)
                            op = RIF;
                    end
                    default: ;
                endcase
            end
        end
        return op;
    endfunction

    assign dec_op  = iot_valid ? decode_iot(instruction) : IOT_NOP;
    assign dec_dev = (dec_op inside {KSF, KCC, KRS, KRB, TSF, TCF, TPC, TLS}) ? dev_tty
                                                                              : dev_cpu;

    assign iot_ready = ~rsp_valid | rsp_ready;
    assign accept    = iot_valid & iot_ready;

    // op goes only to the owning device
    assign tty.op     = (dec_dev == dev_tty) ? dec_op : IOT_NOP;
    assign cpu.op     = (dec_dev == dev_cpu) ? dec_op : IOT_NOP;
    assign tty.field  = instruction[6:8];
    assign cpu.field  = instruction[6:8];
    assign tty.ac     = ac;
    assign cpu.ac     = ac;
    assign tty.strobe = accept & (dec_op != IOT_NOP) & (dec_dev == dev_tty);
    assign cpu.strobe = accept & (dec_op != IOT_NOP) & (dec_dev == dev_cpu);

    assign rd_data = tty.data | cpu.data;

    always_ff @(posedge clk) begin
        if (reset)
            rsp_valid <= 1'b0;
        else if (accept)
            rsp_valid <= 1'b1;
        else if (rsp_ready)
            rsp_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            in_bus   <= rd_data;
            skip     <= tty.skip | cpu.skip;
            clear_ac <= tty.clear_ac | cpu.clear_ac;
        end
    end

    // front panel shows the last transferred word
    always_ff @(posedge clk) begin
        if (reset)
            bus_display <= '0;
        else if (accept) begin
            case (dec_op)
                GTF, KRB:      bus_display <= rd_data;
                ION, TPC, TLS: bus_display <= ac;
                default: ;                                  // hold
            endcase
        end
    end

    a_strobe_accept: assert property (@(posedge clk) disable iff (reset)
        (tty.strobe || cpu.strobe) |-> iot_valid && iot_ready);

    a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=>
            rsp_valid && $stable(in_bus) && $stable(skip) && $stable(clear_ac));

endmodule

`default_nettype wire

//--- verilog/cpu_ctrl_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor control with interrupt enable,
// data and instruction field registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cpu_ctrl_unit
    import pdp8_io_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    iot_if.device link,
    input  logic  tty_flag,
    output logic  int_request
);

    logic   int_en;
    field_t data_field;
    field_t inst_field;

    always_comb begin
        link.data     = '0;
        link.skip     = 1'b0;
        link.clear_ac = 1'b0;
        case (link.op)
            SKON: link.skip = int_en;           // skip then disable
            GTF: begin
                link.data[1]    = int_en;
                link.data[9:11] = data_field;
            end
            RDF: link.data[6:8] = data_field;
            RIF: link.data[6:8] = inst_field;
            default: ;                          // owned elsewhere or no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            int_en     <= 1'b0;
            data_field <= '0;
            inst_field <= '0;
        end else if (link.strobe) begin
            case (link.op)
                ION:       int_en     <= 1'b1;
                IOF, SKON: int_en     <= 1'b0;
                CDF:       data_field <= link.field;
                CIF:       inst_field <= link.field;
                default: ;
            endcase
        end
    end

    // one cycle behind enable and flags
    always_ff @(posedge clk) begin
        if (reset)
            int_request <= 1'b0;
        else
            int_request <= int_en & tty_flag;
    end

endmodule

`default_nettype wire

//--- verilog/tty_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// teletype unit with keyboard buffer and flag,
// printer flag and output byte handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tty_unit
    import pdp8_io_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    iot_if.device             link,
    input  logic              kbd_valid,
    input  logic [0:char_w-1] kbd_data,
    output logic              kbd_ready,
    output logic              tx_valid,
    output logic [0:char_w-1] tx_data,
    input  logic              tx_ready,
    output logic              flag_any
);

    logic [0:char_w-1] kbd_buf;
    logic              kbd_flag;
    logic              prt_flag;
    logic              kbd_take;
    logic              kbd_clear;
    logic              tx_done;
    logic              tx_load;

    assign kbd_ready = ~kbd_flag;
    assign kbd_take  = kbd_valid & kbd_ready;
    assign tx_done   = tx_valid & tx_ready;
    assign flag_any  = kbd_flag | prt_flag;

    assign kbd_clear = link.strobe & (link.op == KCC || link.op == KRB);
    assign tx_load   = link.strobe & (link.op == TPC || link.op == TLS);

    // response from state before the strobe edge
    always_comb begin
        link.data     = '0;
        link.skip     = 1'b0;
        link.clear_ac = 1'b0;
        case (link.op)
            KSF: link.skip = kbd_flag;
            KCC: link.clear_ac = 1'b1;
            KRS: link.data = {4'b0000, kbd_buf};    // byte in bits 4 to 11
            KRB: begin
                link.data     = {4'b0000, kbd_buf};
                link.clear_ac = 1'b1;               // read OR-ed into a cleared AC
            end
            TSF: link.skip = prt_flag;
            default: ;                              // not a teletype op
        endcase
    end

    // keyboard side
    always_ff @(posedge clk) begin
        if (reset) begin
            kbd_flag <= 1'b0;
        end else begin
            if (kbd_clear)
                kbd_flag <= 1'b0;
            if (kbd_take)
                kbd_flag <= 1'b1;                   // new character wins
        end
    end

    always_ff @(posedge clk) begin
        if (kbd_take)
            kbd_buf <= kbd_data;
    end

    // printer side
    always_ff @(posedge clk) begin
        if (reset) begin
            prt_flag <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            if (tx_done) begin
                tx_valid <= 1'b0;
                prt_flag <= 1'b1;                   // character printed
            end
            if (link.strobe && (link.op == TCF || link.op == TLS))
                prt_flag <= 1'b0;
            if (tx_load)
                tx_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_load)
            tx_data <= link.ac[4:11];               // overwrites a pending byte
    end

    // pending byte holds until taken or replaced by TPC/TLS
    a_tx_hold: assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready && !tx_load |=> tx_valid && $stable(tx_data));

endmodule

`default_nettype wire

//--- verilog/iot_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link between io_mux and one IOT device
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

// one instance per device, selected in io_mux by dev_tty or dev_cpu
interface iot_if
    import pdp8_io_pkg::*;
();

    iot_op_e op;        // decoded op, IOT_NOP when not addressed
    field_t  field;     // field N of CDF and CIF
    word_t   ac;        // accumulator of the request
    logic    strobe;    // side effects apply on this edge

    word_t   data;      // returned word, OR-ed into in_bus
    logic    skip;
    logic    clear_ac;

    modport host (
        output op, field, ac, strobe,
        input  data, skip, clear_ac
    );

    modport device (
        input  op, field, ac, strobe,
        output data, skip, clear_ac
    );

endinterface

`default_nettype wire

//--- verilog/pdp8_io_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared word and field types, decoded IOT operations
// and the device codes of the IOT path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pdp8_io_pkg;

    localparam int field_w = 3;           // memory field number width
    localparam int char_w  = 8;           // keyboard and printer byte width

    // machine word, bit 0 is the most significant
    typedef logic [0:11]        word_t;
    typedef logic [0:field_w-1] field_t;

    // major opcode of every IOT instruction
    localparam logic [0:2] iot_opcode   = 3'o6;

    // device codes, instruction bits 3 to 8
    localparam logic [0:5] dev_code_cpu = 6'o00;  // interrupt control
    localparam logic [0:5] dev_code_kbd = 6'o03;  // teletype keyboard
    localparam logic [0:5] dev_code_prt = 6'o04;  // teletype printer

    // memory field group 62N, instruction bits 3 to 5
    localparam logic [0:2] mem_group    = 3'o2;

    // link select inside io_mux
    localparam logic dev_tty = 1'b0;
    localparam logic dev_cpu = 1'b1;

    typedef enum logic [4:0] {
        IOT_NOP,
        // processor control
        ION,        // 6001
        IOF,        // 6002
        SKON,       // 6000 and 6003
        GTF,        // 6004
        CDF,        // 62N1
        CIF,        // 62N2
        RDF,        // 6214
        RIF,        // 6224
        // keyboard
        KSF,        // 6031
        KCC,        // 6032
        KRS,        // 6034
        KRB,        // 6036
        // printer
        TSF,        // 6041
        TCF,        // 6042
        TPC,        // 6044
        TLS         // 6046
    } iot_op_e;

endpackage

`default_nettype wire
